// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  tag_t;
	typedef logic [4:0]  reg_index_t;
	typedef logic [2:0]  mem_width_t;

	// Access width in bytes
	localparam mem_width_t WIDTH_BYTE = 3'd1;
	localparam mem_width_t WIDTH_HALF = 3'd2;
	localparam mem_width_t WIDTH_WORD = 3'd4;

	// Record from the execute stage
	typedef struct packed {
		tag_t       tag;
		logic       mem_read;
		logic       mem_write;
		logic       mem_flush;
		mem_width_t mem_width;
		logic       mem_signed;
		word_t      mem_address;
		word_t      rd;
		reg_index_t inst_rd;
		reg_index_t mem_inst_rd;
	} execute_data_t;

	// Retired record
	typedef struct packed {
		tag_t       tag;
		word_t      rd;
		reg_index_t inst_rd;
	} memory_data_t;

	// Data cache geometry with one word per line
	localparam int DCACHE_INDEX_BITS = 6;
	localparam int DCACHE_TAG_BITS   = 30 - DCACHE_INDEX_BITS;
	localparam int DCACHE_LINES      = 1 << DCACHE_INDEX_BITS;

	typedef logic [DCACHE_INDEX_BITS-1:0] dcache_index_t;
	typedef logic [DCACHE_TAG_BITS-1:0]   dcache_tag_t;

	// SDRAM region has top nibble 2 or 3
	localparam logic [3:0] CACHEABLE_HI0 = 4'h2;
	localparam logic [3:0] CACHEABLE_HI1 = 4'h3;

	function automatic logic is_cacheable(input word_t address);
		return (address[31:28] == CACHEABLE_HI0) || (address[31:28] == CACHEABLE_HI1);
	endfunction

	function automatic dcache_index_t line_index(input word_t address);
		return address[DCACHE_INDEX_BITS+1:2];
	endfunction

	function automatic dcache_tag_t line_tag(input word_t address);
		return address[31:DCACHE_INDEX_BITS+2];
	endfunction

endpackage

// ==== hdl/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
	input  logic                 i_clock,
	input  logic                 i_rst_n,

	input  mem_pkg::execute_data_t i_data,
	output logic                 o_busy,
	output mem_pkg::memory_data_t  o_data,

	output logic                 o_cache_request,
	output logic                 o_cache_rw,
	output logic                 o_cache_flush,
	output mem_pkg::word_t       o_cache_address,
	output mem_pkg::word_t       o_cache_wdata,
	input  logic                 i_cache_ready,
	input  mem_pkg::word_t       i_cache_rdata
);

	import mem_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_RMW_READ,
		ST_RMW_WRITE,
		ST_FLUSH
	} state_t;

	state_t state;

	logic         new_record;
	logic [1:0]   byte_offset;
	word_t        shifted;
	word_t        load_result;
	word_t        merged_word;
	memory_data_t retire_rec;
	memory_data_t load_rec;

	assign new_record  = (i_data.tag != o_data.tag);
	assign byte_offset = i_data.mem_address[1:0];

	assign o_busy = new_record &&
		(i_data.mem_read || i_data.mem_write || i_data.mem_flush);

	// Cache works on whole words only
	assign o_cache_address = {i_data.mem_address[31:2], 2'b00};

	// Load extraction and extension
	always_comb begin
		shifted = i_cache_rdata >> {byte_offset, 3'b000};
		case (i_data.mem_width)
			WIDTH_WORD: load_result = i_cache_rdata;
			WIDTH_HALF: load_result = {{16{i_data.mem_signed & shifted[15]}}, shifted[15:0]};
			WIDTH_BYTE: load_result = {{24{i_data.mem_signed & shifted[7]}}, shifted[7:0]};
			default:    load_result = '0;
		endcase
	end

	// Merge of a sub-word store into the word just read
	always_comb begin
		merged_word = i_cache_rdata;
		if (i_data.mem_width == WIDTH_BYTE) begin
			merged_word[{byte_offset, 3'b000} +: 8] = i_data.rd[7:0];
		end else begin
			case (byte_offset)
				2'd0:    merged_word[15:0]  = i_data.rd[15:0];
				2'd2:    merged_word[31:16] = i_data.rd[15:0];
				default: merged_word = '0;
			endcase
		end
	end

	assign retire_rec = '{tag: i_data.tag, rd: i_data.rd, inst_rd: i_data.inst_rd};
	assign load_rec   = '{tag: i_data.tag, rd: load_result, inst_rd: i_data.mem_inst_rd};

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state           <= ST_IDLE;
			o_cache_request <= 1'b0;
			o_cache_rw      <= 1'b0;
			o_cache_flush   <= 1'b0;
			o_data          <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					o_cache_request <= 1'b0;
					o_cache_rw      <= 1'b0;
					o_cache_flush   <= 1'b0;
					if (new_record) begin
						if (i_data.mem_read) begin
							o_cache_request <= 1'b1;
							state           <= ST_READ;
						end else if (i_data.mem_write) begin
							o_cache_request <= 1'b1;
							if (i_data.mem_width == WIDTH_WORD) begin
								o_cache_rw    <= 1'b1;
								o_cache_wdata <= i_data.rd;
								state         <= ST_WRITE_WORD;
							end else begin
								state <= ST_RMW_READ;
							end
						end else if (i_data.mem_flush) begin
							o_cache_request <= 1'b1;
							o_cache_flush   <= 1'b1;
							state           <= ST_FLUSH;
						end else begin
							o_data <= retire_rec;
						end
					end
				end

				ST_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_data          <= load_rec;
						state           <= ST_IDLE;
					end
				end

				ST_WRITE_WORD, ST_FLUSH: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_rw      <= 1'b0;
						o_cache_flush   <= 1'b0;
						o_data          <= retire_rec;
						state           <= ST_IDLE;
					end
				end

				ST_RMW_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_wdata   <= merged_word;
						state           <= ST_RMW_WRITE;
					end
				end

				ST_RMW_WRITE: begin
					// Request was dropped after the read, raise it again
					if (!o_cache_request) begin
						o_cache_request <= 1'b1;
						o_cache_rw      <= 1'b1;
					end else if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_rw      <= 1'b0;
						o_data          <= retire_rec;
						state           <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	a_flush_not_rw: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_cache_request |-> !(o_cache_flush && o_cache_rw));

	// Request held until the cache answers
	a_request_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_cache_request && !i_cache_ready |=> o_cache_request);

endmodule

// ==== hdl/data_cache.sv ====
`timescale 1ns/10ps

module data_cache (
	input  logic           i_clock,
	input  logic           i_rst_n,

	input  logic           i_request,
	input  logic           i_rw,
	input  logic           i_flush,
	input  mem_pkg::word_t i_address,
	input  mem_pkg::word_t i_wdata,
	output logic           o_ready,
	output mem_pkg::word_t o_rdata,

	output logic           o_bus_request,
	output logic           o_bus_rw,
	output mem_pkg::word_t o_bus_address,
	output mem_pkg::word_t o_bus_wdata,
	input  logic           i_bus_ready,
	input  mem_pkg::word_t i_bus_rdata
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_FLUSH
	} state_t;

	state_t state;

	logic [DCACHE_LINES-1:0] valid;
	dcache_tag_t             tag_mem  [DCACHE_LINES];
	word_t                   data_mem [DCACHE_LINES];

	dcache_index_t index;
	dcache_index_t flush_index;
	logic          cacheable;
	logic          hit;
	logic          start;
	logic          line_write;
	word_t         line_wdata;

	assign index     = line_index(i_address);
	assign cacheable = is_cacheable(i_address);
	assign hit       = cacheable && valid[index] && (tag_mem[index] == line_tag(i_address));

	// Request still high during the ready pulse is the old one
	assign start = i_request && !o_ready;

	// Read miss fills the line, write hit updates it
	assign line_write = (state == ST_BUS) && i_bus_ready && cacheable && (!i_rw || hit);
	assign line_wdata = i_rw ? i_wdata : i_bus_rdata;

	always_ff @(posedge i_clock) begin
		if (line_write) begin
			tag_mem[index]  <= line_tag(i_address);
			data_mem[index] <= line_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state         <= ST_IDLE;
			valid         <= '0;
			o_ready       <= 1'b0;
			o_bus_request <= 1'b0;
			o_bus_rw      <= 1'b0;
			flush_index   <= '0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						if (i_flush) begin
							flush_index <= '0;
							state       <= ST_FLUSH;
						end else if (!i_rw && hit) begin
							o_rdata <= data_mem[index];
							o_ready <= 1'b1;
						end else begin
							o_bus_request <= 1'b1;
							o_bus_rw      <= i_rw;
							o_bus_address <= i_address;
							o_bus_wdata   <= i_wdata;
							state         <= ST_BUS;
						end
					end
				end

				ST_BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw      <= 1'b0;
						o_rdata       <= i_bus_rdata;
						o_ready       <= 1'b1;
						if (line_write) begin
							valid[index] <= 1'b1;
						end
						state <= ST_IDLE;
					end
				end

				ST_FLUSH: begin
					valid[flush_index] <= 1'b0;
					flush_index        <= flush_index + 1'b1;
					if (&flush_index) begin
						o_ready <= 1'b1;
						state   <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	a_bus_request_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request);

endmodule

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	input  mem_pkg::execute_data_t i_data,
	output logic                   o_busy,
	output mem_pkg::memory_data_t  o_data,

	output logic                   o_bus_request,
	output logic                   o_bus_rw,
	output mem_pkg::word_t         o_bus_address,
	output mem_pkg::word_t         o_bus_wdata,
	input  logic                   i_bus_ready,
	input  mem_pkg::word_t         i_bus_rdata
);

	import mem_pkg::*;

	logic  cache_request;
	logic  cache_rw;
	logic  cache_flush;
	logic  cache_ready;
	word_t cache_address;
	word_t cache_wdata;
	word_t cache_rdata;

	mem_stage u_mem_stage (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_data          (i_data),
		.o_busy          (o_busy),
		.o_data          (o_data),
		.o_cache_request (cache_request),
		.o_cache_rw      (cache_rw),
		.o_cache_flush   (cache_flush),
		.o_cache_address (cache_address),
		.o_cache_wdata   (cache_wdata),
		.i_cache_ready   (cache_ready),
		.i_cache_rdata   (cache_rdata)
	);

	// Cache drives the external bus directly
	data_cache u_data_cache (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_request     (cache_request),
		.i_rw          (cache_rw),
		.i_flush       (cache_flush),
		.i_address     (cache_address),
		.i_wdata       (cache_wdata),
		.o_ready       (cache_ready),
		.o_rdata       (cache_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #2 o_clock = ~o_clock;
	end

	// Reset low over two rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clock);
		@(negedge o_clock);
		o_rst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_bus_memory.sv ====
`timescale 1ns/10ps

module tb_bus_memory (
	input  logic           i_clock,
	input  logic           i_rst_n,
	input  logic           i_request,
	input  logic           i_rw,
	input  mem_pkg::word_t i_address,
	input  mem_pkg::word_t i_wdata,
	output logic           o_ready,
	output mem_pkg::word_t o_rdata,
	output int             o_read_count
);

	import mem_pkg::*;

	localparam word_t FILL_KEY = 32'hA55A_C38E;

	word_t       words [logic [29:0]];
	logic        ready      = 1'b0;
	word_t       rdata      = '0;
	int          read_count = 0;
	logic        pending    = 1'b0;
	int          countdown  = 0;
	logic [15:0] lfsr       = 16'd91;
	logic [1:0]  delay_bits;

	assign o_ready      = ready;
	assign o_rdata      = rdata;
	assign o_read_count = read_count;

	// Galois LFSR stepped once per random bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// Unwritten words read back as their byte address mixed with a key
	function automatic word_t read_word(input logic [29:0] word_address);
		if (words.exists(word_address)) begin
			return words[word_address];
		end
		return {word_address, 2'b00} ^ FILL_KEY;
	endfunction

	always @(negedge i_clock) begin
		if (!i_rst_n) begin
			ready   <= 1'b0;
			pending = 1'b0;
		end else if (ready) begin
			ready <= 1'b0;
		end else if (i_request) begin
			if (!pending) begin
				lfsr          = lfsr_step(lfsr);
				delay_bits[0] = lfsr[0];
				lfsr          = lfsr_step(lfsr);
				delay_bits[1] = lfsr[0];
				countdown     = int'(delay_bits) + 1;
				pending       = 1'b1;
			end
			countdown = countdown - 1;
			if (countdown == 0) begin
				pending = 1'b0;
				ready   <= 1'b1;
				if (i_rw) begin
					words[i_address[31:2]] = i_wdata;
				end else begin
					rdata      <= read_word(i_address[31:2]);
					read_count <= read_count + 1;
				end
			end
		end
	end

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  mem_pkg::execute_data_t i_data,
	input  logic                   i_busy,
	input  mem_pkg::memory_data_t  i_retired,
	input  int                     i_read_count,
	input  mem_pkg::memory_data_t  i_expected,
	input  int                     i_expected_reads,
	output int                     o_checked,
	output int                     o_failed
);

	import mem_pkg::*;

	logic active  = 1'b0;
	logic busy_seen;
	logic is_memory;
	int   base_reads;
	int   cycles;
	int   errors;
	int   checked = 0;
	int   failed  = 0;

	assign o_checked = checked;
	assign o_failed  = failed;
	assign is_memory = i_data.mem_read || i_data.mem_write || i_data.mem_flush;

	function automatic int compare_record(input int reads_seen);
		int wrong;
		wrong = 0;
		if (i_retired.rd !== i_expected.rd) begin
			$display("Mismatch at time %0t: tag %0d rd 0x%08h, expected 0x%08h",
				$time, i_data.tag, i_retired.rd, i_expected.rd);
			wrong++;
		end
		if (i_retired.inst_rd !== i_expected.inst_rd) begin
			$display("Mismatch at time %0t: tag %0d inst_rd %0d, expected %0d",
				$time, i_data.tag, i_retired.inst_rd, i_expected.inst_rd);
			wrong++;
		end
		if (reads_seen != i_expected_reads) begin
			$display("Mismatch at time %0t: tag %0d made %0d bus reads, expected %0d",
				$time, i_data.tag, reads_seen, i_expected_reads);
			wrong++;
		end
		if (busy_seen != is_memory) begin
			$display("Mismatch at time %0t: tag %0d busy %0b, expected %0b",
				$time, i_data.tag, busy_seen, is_memory);
			wrong++;
		end
		// Plain records retire on the next edge
		if (!is_memory && cycles != 1) begin
			$display("Mismatch at time %0t: tag %0d retired after %0d cycles, expected 1",
				$time, i_data.tag, cycles);
			wrong++;
		end
		return wrong;
	endfunction

	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			active = 1'b0;
		end else if (!active) begin
			if (i_data.tag != i_retired.tag) begin
				active     = 1'b1;
				base_reads = i_read_count;
				busy_seen  = i_busy;
				cycles     = 0;
			end
		end else begin
			cycles    = cycles + 1;
			busy_seen = busy_seen | i_busy;
			if (i_retired.tag == i_data.tag) begin
				errors  = compare_record(i_read_count - base_reads);
				checked = checked + 1;
				if (errors != 0) begin
					failed = failed + 1;
				end
				$display("Row %0d tag %0d: %s after %0d cycles", checked, i_data.tag,
					(errors == 0) ? "ok" : "FAILED", cycles);
				active = 1'b0;
			end
		end
	end

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

module tb_mem_subsystem;

	import mem_pkg::*;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_LOAD,
		OP_STORE,
		OP_FLUSH
	} op_t;

	typedef struct packed {
		op_t        op;
		mem_width_t width;
		logic       sign_ext;
		word_t      address;
		word_t      rd;
		reg_index_t inst_rd;
		reg_index_t mem_inst_rd;
		word_t      exp_rd;
		reg_index_t exp_inst_rd;
		logic [3:0] exp_reads;
	} row_t;

	localparam int    WAIT_LIMIT = 200;
	localparam word_t CACHED     = 32'h2000_0100;
	localparam word_t UNCACHED   = 32'h1000_0040;

	logic          clock;
	logic          rst_n;
	execute_data_t exec_data;
	memory_data_t  retired;
	logic          busy;
	logic          bus_request;
	logic          bus_rw;
	word_t         bus_address;
	word_t         bus_wdata;
	logic          bus_ready;
	word_t         bus_rdata;
	int            read_count;
	memory_data_t  expected;
	int            expected_reads;
	int            checked;
	int            failed;
	logic          timed_out;
	row_t          rows [$];

	tb_clock_gen u_clock_gen (
		.o_clock (clock),
		.o_rst_n (rst_n)
	);

	mem_subsystem u_dut (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_data        (exec_data),
		.o_busy        (busy),
		.o_data        (retired),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	tb_bus_memory u_bus_memory (
		.i_clock      (clock),
		.i_rst_n      (rst_n),
		.i_request    (bus_request),
		.i_rw         (bus_rw),
		.i_address    (bus_address),
		.i_wdata      (bus_wdata),
		.o_ready      (bus_ready),
		.o_rdata      (bus_rdata),
		.o_read_count (read_count)
	);

	tb_checker u_checker (
		.i_clock          (clock),
		.i_rst_n          (rst_n),
		.i_data           (exec_data),
		.i_busy           (busy),
		.i_retired        (retired),
		.i_read_count     (read_count),
		.i_expected       (expected),
		.i_expected_reads (expected_reads),
		.o_checked        (checked),
		.o_failed         (failed)
	);

	task automatic add_row(input op_t op, input mem_width_t width, input logic sign_ext,
		input word_t address, input word_t rd, input reg_index_t inst_rd,
		input reg_index_t mem_inst_rd, input word_t exp_rd, input reg_index_t exp_inst_rd,
		input int exp_reads);
		rows.push_back('{op, width, sign_ext, address, rd, inst_rd, mem_inst_rd,
			exp_rd, exp_inst_rd, 4'(exp_reads)});
	endtask

	// Memory word at CACHED is 855A_C28E, at UNCACHED B55A_C3CE
	task automatic fill_table();
		add_row(OP_NONE, 3'd0, 1'b0, '0, 32'h1234_5678, 5'd5, 5'd0, 32'h1234_5678, 5'd5, 0);
		add_row(OP_LOAD, 3'd4, 1'b0, CACHED, '0, 5'd3, 5'd7, 32'h855A_C28E, 5'd7, 1);
		add_row(OP_LOAD, 3'd4, 1'b0, CACHED, '0, 5'd3, 5'd8, 32'h855A_C28E, 5'd8, 0);
		add_row(OP_LOAD, 3'd2, 1'b1, CACHED + 2, '0, 5'd3, 5'd9, 32'hFFFF_855A, 5'd9, 0);
		add_row(OP_LOAD, 3'd2, 1'b0, CACHED, '0, 5'd3, 5'd10, 32'h0000_C28E, 5'd10, 0);
		add_row(OP_LOAD, 3'd1, 1'b1, CACHED + 1, '0, 5'd3, 5'd11, 32'hFFFF_FFC2, 5'd11, 0);
		add_row(OP_LOAD, 3'd1, 1'b1, CACHED + 2, '0, 5'd3, 5'd12, 32'h0000_005A, 5'd12, 0);
		add_row(OP_LOAD, 3'd1, 1'b0, CACHED + 3, '0, 5'd3, 5'd13, 32'h0000_0085, 5'd13, 0);
		add_row(OP_LOAD, 3'd4, 1'b0, UNCACHED, '0, 5'd3, 5'd14, 32'hB55A_C3CE, 5'd14, 1);
		add_row(OP_LOAD, 3'd4, 1'b0, UNCACHED, '0, 5'd3, 5'd15, 32'hB55A_C3CE, 5'd15, 1);
		add_row(OP_LOAD, 3'd2, 1'b1, UNCACHED + 2, '0, 5'd3, 5'd16, 32'hFFFF_B55A, 5'd16, 1);
		add_row(OP_LOAD, 3'd1, 1'b0, UNCACHED, '0, 5'd3, 5'd17, 32'h0000_00CE, 5'd17, 1);
		// Sub-word stores merge into the word read first
		add_row(OP_STORE, 3'd1, 1'b0, CACHED + 1, 32'h0000_0033, 5'd9, 5'd0,
			32'h0000_0033, 5'd9, 0);
		add_row(OP_STORE, 3'd2, 1'b0, CACHED + 2, 32'hBEEF_7E11, 5'd10, 5'd0,
			32'hBEEF_7E11, 5'd10, 0);
		add_row(OP_LOAD, 3'd4, 1'b0, CACHED, '0, 5'd3, 5'd18, 32'h7E11_338E, 5'd18, 0);
		add_row(OP_STORE, 3'd1, 1'b0, UNCACHED + 3, 32'h0000_00A7, 5'd11, 5'd0,
			32'h0000_00A7, 5'd11, 1);
		add_row(OP_STORE, 3'd2, 1'b0, UNCACHED, 32'h0000_1D2C, 5'd12, 5'd0,
			32'h0000_1D2C, 5'd12, 1);
		add_row(OP_LOAD, 3'd4, 1'b0, UNCACHED, '0, 5'd3, 5'd19, 32'hA75A_1D2C, 5'd19, 1);
		add_row(OP_FLUSH, 3'd0, 1'b0, '0, 32'h0000_0F0F, 5'd4, 5'd0, 32'h0000_0F0F, 5'd4, 0);
		add_row(OP_LOAD, 3'd4, 1'b0, CACHED, '0, 5'd3, 5'd20, 32'h7E11_338E, 5'd20, 1);
		add_row(OP_NONE, 3'd0, 1'b0, '0, 32'hCAFE_0001, 5'd21, 5'd0, 32'hCAFE_0001, 5'd21, 0);
	endtask

	task automatic drive_row(input row_t row, input tag_t tag);
		exec_data             = '0;
		exec_data.tag         = tag;
		exec_data.mem_read    = (row.op == OP_LOAD);
		exec_data.mem_write   = (row.op == OP_STORE);
		exec_data.mem_flush   = (row.op == OP_FLUSH);
		exec_data.mem_width   = row.width;
		exec_data.mem_signed  = row.sign_ext;
		exec_data.mem_address = row.address;
		exec_data.rd          = row.rd;
		exec_data.inst_rd     = row.inst_rd;
		exec_data.mem_inst_rd = row.mem_inst_rd;
		expected       = '{tag: tag, rd: row.exp_rd, inst_rd: row.exp_inst_rd};
		expected_reads = int'(row.exp_reads);
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (!rst_n && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (!rst_n) begin
			$display("Reset was never released");
			timed_out = 1'b1;
		end
		@(negedge clock);
	endtask

	task automatic wait_for_retire(input int row);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (checked < row && cycles < WAIT_LIMIT);
		if (checked < row) begin
			$display("Row %0d did not retire within %0d cycles", row, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_run();
		int fails;
		fails = failed + (timed_out ? 1 : 0);
		$display("Rows passed: %0d, failed: %0d", checked - failed, fails);
		if (fails == 0 && checked == rows.size()) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	initial begin
		exec_data      = '0;
		expected       = '0;
		expected_reads = 0;
		timed_out      = 1'b0;
		fill_table();
		wait_for_reset();
		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			drive_row(rows[i], tag_t'(i + 1));
			wait_for_retire(i + 1);
		end
		finish_run();
	end

endmodule

// ==== mem_subsystem.f ====
hdl/mem_pkg.sv
hdl/mem_stage.sv
hdl/data_cache.sv
hdl/mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_bus_memory.sv
testbench/tb_checker.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
TOP = tb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mem_subsystem.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
